// File: testbench/mmu_stim.txt
# M pa data | C satp_mode root_ppn priv(0 U,1 S,3 M) sum | F flush both TLBs
# R side(i/d) access(L/S/F) vaddr exp_paddr exp_fault exp_reads | D fetch_va pa fault load_va pa fault
M 000010004 00004401
M 000010008 081000CF
M 00001000C 081004CF
M 000011000 080000C7
M 000011004 08000443
M 000011008 08000849
M 00001100C 08000C00
M 000011010 08001045
M 000011014 08001401
M 000011018 0800185F
M 00001101C 08001CC7
C 0 00010 1 0
R d L 00401234 000401234 0 0
R i F 80000ABC 080000ABC 0 0
C 1 00010 3 0
R d S 00402010 000402010 0 0
C 1 00010 1 0
R d L 00400123 020000123 0 2
R d S 00400456 020000456 0 0
R i F 00402ABC 020002ABC 0 2
R i F 00402FFC 020002FFC 0 0
R d L 00401008 020001008 0 2
R d S 00401008 000000000 1 0
R d L 00403000 000000000 1 2
R d L 00404000 000000000 1 2
R d L 00405000 000000000 1 2
R i F 00400000 000000000 1 2
R d L 00835678 020435678 0 1
R d L 00C00010 000000000 1 1
C 1 00010 0 0
R d L 00400010 000000000 1 0
R d L 00406010 020006010 0 2
C 1 00010 1 0
R d L 00406020 000000000 1 0
C 1 00010 1 1
R d L 00406030 020006030 0 0
F
R d S 00401010 000000000 1 2
R d L 00407010 020007010 0 2
M 00001101C 0C001CC7
R d L 00407020 020007020 0 0
F
R d L 00407030 030007030 0 2
F
D 00402100 020002100 0 00400200 020000200 0
R i F 00402104 020002104 0 0
R d L 00400204 020000204 0 0

// File: src.f
+incdir+common
common/priv_types_pkg.sv
common/sv32_types_pkg.sv
tlb/tlb.sv
page_walker/page_walker.sv
rtl/mmu_top.sv
testbench/tb_page_table_mem.sv
testbench/mmu_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary -f src.f --top-module mmu_tb -o mmu_sim > build.log 2>&1 \
    || { cat build.log; exit 1; }
./obj_dir/mmu_sim > sim.log 2>&1
cat sim.log
grep -q "All checks passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: testbench/mmu_tb.sv
// reads testbench/mmu_stim.txt from the project root; D lines pair a fetch with a load
`timescale 1ns/1ps
`include "mmu_defs.svh"

module mmu_tb;

    import priv_types_pkg::*;
    import sv32_types_pkg::*;

    logic       CLK;
    logic       nRST;
    csr_state_t csr;
    logic       flush;
    tlb_req_t   ireq;
    tlb_req_t   dreq;
    tlb_rsp_t   irsp;
    tlb_rsp_t   drsp;
    mem_req_t   mem_req;
    mem_rsp_t   mem_rsp;
    logic       load_en;
    paddr_t     load_addr;
    word_t      load_data;

    string  stim_lines[$];
    int     stim_line_nos[$];  // file line of each entry, for test names
    int     error_count = 0;
    longint limit_ns = 0;

    mmu_top uut (
        .CLK     (CLK),
        .nRST    (nRST),
        .csr     (csr),
        .flush   (flush),
        .ireq    (ireq),
        .dreq    (dreq),
        .irsp    (irsp),
        .drsp    (drsp),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

    tb_page_table_mem pt_mem (
        .CLK       (CLK),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .mem_req   (mem_req),
        .mem_rsp   (mem_rsp)
    );

    always #50 CLK = ~CLK;

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (expected !== actual) begin
            error_count++;
            $display("MISMATCH %s expected %h actual %h", name, expected, actual);
            $display("Checks failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic stop_on_bad_stim(input int line_no);
        $display("stim line %0d could not be parsed", line_no);
        $display("Checks failed");
        $fatal(1, "bad stimulus");
    endtask

    function automatic access_t access_of(input logic [7:0] c);
        case (c)
            "L": return LOAD;
            "S": return STORE;
            "F": return FETCH;
            default: return NONE;
        endcase
    endfunction

    task automatic write_word(input paddr_t addr, input word_t data);
        @(negedge CLK);
        load_en   = 1'b1;
        load_addr = addr;
        load_data = data;
        @(negedge CLK);
        load_en = 1'b0;
    endtask

    task automatic set_csr(input int mode, input ppn_t root, input int priv, input int sum);
        @(negedge CLK);
        csr.satp.mode = mode[0];
        csr.satp.asid = '0;
        csr.satp.ppn  = root;
        csr.priv      = priv_level_t'(priv[1:0]);  // 0 U, 1 S, 3 M
        csr.sum       = sum[0];
    endtask

    task automatic flush_tlbs();
        @(negedge CLK);
        flush = 1'b1;
        @(negedge CLK);
        flush = 1'b0;
    endtask

    // one request on one side, reads counted as completed memory reads
    task automatic translate_one(input int line_no, input logic [7:0] side, input access_t acc,
                                 input word_t va, input paddr_t exp_pa, input int exp_fault,
                                 input int exp_reads);
        tlb_rsp_t rsp;
        int       reads;
        logic     done_seen;
        rsp       = '0;
        reads     = 0;
        done_seen = 1'b0;
        @(negedge CLK);
        if (side == "i") begin
            ireq.valid  = 1'b1;
            ireq.access = acc;
            ireq.vaddr  = va;
        end else begin
            dreq.valid  = 1'b1;
            dreq.access = acc;
            dreq.vaddr  = va;
        end
        while (!done_seen) begin
            @(negedge CLK);
            if (mem_req.ren && !mem_rsp.busy)
                reads++;
            rsp       = (side == "i") ? irsp : drsp;
            done_seen = rsp.done;
        end
        ireq.valid = 1'b0;  // dropped at the done cycle
        dreq.valid = 1'b0;
        check_value($sformatf("line %0d fault", line_no), 64'(exp_fault), 64'(rsp.fault));
        if (exp_fault == 0)
            check_value($sformatf("line %0d paddr", line_no), 64'(exp_pa), 64'(rsp.paddr));
        check_value($sformatf("line %0d memory reads", line_no), 64'(exp_reads), 64'(reads));
    endtask

    // fetch and load raised in the same cycle
    task automatic translate_pair(input int line_no, input word_t iva, input paddr_t iexp,
                                  input int ifault, input word_t dva, input paddr_t dexp,
                                  input int dfault);
        tlb_rsp_t ir;
        tlb_rsp_t dr;
        int       cycle;
        int       i_at;
        int       d_at;
        ir    = '0;
        dr    = '0;
        cycle = 0;
        i_at  = -1;
        d_at  = -1;
        @(negedge CLK);
        ireq.valid  = 1'b1;
        ireq.access = FETCH;
        ireq.vaddr  = iva;
        dreq.valid  = 1'b1;
        dreq.access = LOAD;
        dreq.vaddr  = dva;
        while (i_at < 0 || d_at < 0) begin
            @(negedge CLK);
            cycle++;
            if (irsp.done) begin
                i_at       = cycle;
                ir         = irsp;
                ireq.valid = 1'b0;
            end
            if (drsp.done) begin
                d_at       = cycle;
                dr         = drsp;
                dreq.valid = 1'b0;
            end
        end
        check_value($sformatf("line %0d fetch fault", line_no), 64'(ifault), 64'(ir.fault));
        if (ifault == 0)
            check_value($sformatf("line %0d fetch paddr", line_no), 64'(iexp), 64'(ir.paddr));
        check_value($sformatf("line %0d load fault", line_no), 64'(dfault), 64'(dr.fault));
        if (dfault == 0)
            check_value($sformatf("line %0d load paddr", line_no), 64'(dexp), 64'(dr.paddr));
        check_value($sformatf("line %0d data first", line_no), 64'(1), 64'(d_at < i_at));
    endtask

    task automatic apply_stim_line(input string line, input int line_no);
        logic [7:0] kind;
        logic [7:0] side;
        logic [7:0] acc_c;
        paddr_t     addr;
        paddr_t     exp_pa;
        paddr_t     exp_pa2;
        word_t      data;
        word_t      va;
        word_t      va2;
        ppn_t       root;
        int         f1;
        int         f2;
        int         f3;
        int         f4;
        int         n;
        kind = line[0];
        case (kind)
            "M": begin
                n = $sscanf(line, "%c %h %h", kind, addr, data);
                if (n != 3)
                    stop_on_bad_stim(line_no);
                write_word(addr, data);
            end
            "C": begin
                n = $sscanf(line, "%c %d %h %d %d", kind, f1, root, f2, f3);
                if (n != 5)
                    stop_on_bad_stim(line_no);
                set_csr(f1, root, f2, f3);
            end
            "F": flush_tlbs();
            "R": begin
                n = $sscanf(line, "%c %c %c %h %h %d %d", kind, side, acc_c, va, exp_pa, f1, f2);
                if (n != 7)
                    stop_on_bad_stim(line_no);
                translate_one(line_no, side, access_of(acc_c), va, exp_pa, f1, f2);
            end
            "D": begin
                n = $sscanf(line, "%c %h %h %d %h %h %d", kind, va, exp_pa, f3, va2, exp_pa2, f4);
                if (n != 7)
                    stop_on_bad_stim(line_no);
                translate_pair(line_no, va, exp_pa, f3, va2, exp_pa2, f4);
            end
            default: stop_on_bad_stim(line_no);
        endcase
    endtask

    initial begin : main
        int    fd;
        int    line_no;
        int    req_count;
        int    other_count;
        string line;
        CLK       = 1'b0;
        nRST      = 1'b0;
        csr       = '0;
        flush     = 1'b0;
        ireq      = '0;
        dreq      = '0;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        fd = $fopen("testbench/mmu_stim.txt", "r");
        if (fd == 0) begin
            $display("cannot open testbench/mmu_stim.txt");
            $display("Checks failed");
            $fatal(1, "no stimulus");
        end
        line_no     = 0;
        req_count   = 0;
        other_count = 0;
        while ($fgets(line, fd) != 0) begin
            line_no++;
            if (line.len() == 0 || line[0] == "#" || line[0] == "\n" || line[0] == "\r")
                continue;
            stim_lines.push_back(line);
            stim_line_nos.push_back(line_no);
            if (line[0] == "R")
                req_count++;
            else if (line[0] == "D")
                req_count += 2;
            else
                other_count++;  // two cycles each
        end
        $fclose(fd);
        limit_ns = longint'(req_count * (`SV32_LEVELS * `MEM_MAX_LAT + 8) +
                            2 * other_count + 8) * 100;
        repeat (2) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;
        foreach (stim_lines[k])
            apply_stim_line(stim_lines[k], stim_line_nos[k]);
        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin : watchdog
        wait (limit_ns != 0);
        #(limit_ns);
        $display("simulation timed out waiting for done");
        $display("Checks failed");
        $fatal(1, "watchdog expired");
    end

endmodule

// File: testbench/tb_page_table_mem.sv
// reads only, word addressed by pa[33:2]; unloaded words read as zero, which is an invalid PTE
`timescale 1ns/1ps
`include "mmu_defs.svh"

module tb_page_table_mem (
    input  logic                     CLK,
    input  logic                     load_en,
    input  priv_types_pkg::paddr_t   load_addr,
    input  priv_types_pkg::word_t    load_data,
    input  sv32_types_pkg::mem_req_t mem_req,
    output sv32_types_pkg::mem_rsp_t mem_rsp
);

    import priv_types_pkg::*;
    import sv32_types_pkg::*;

    word_t mem [logic [`PA_WIDTH-3:0]];

    int seed = 32'h7ce3_8dfc;
    int elapsed = 0;  // cycles already spent on the current read
    int extra = 0;    // busy cycles before the current read completes

    // loads come from the stim reader
    always @(posedge CLK) begin
        if (load_en)
            mem[load_addr[`PA_WIDTH-1:2]] = load_data;
    end

    // a read completes in the first cycle where busy is low
    always @(posedge CLK) begin
        if (mem_req.ren) begin
            if (elapsed < extra) begin
                elapsed <= elapsed + 1;
            end else begin
                elapsed <= 0;
                extra   <= int'($unsigned($random(seed)) % `MEM_MAX_LAT);  // next read
            end
        end
    end

    always_comb begin
        mem_rsp.busy  = mem_req.ren && (elapsed < extra);
        mem_rsp.rdata = '0;
        if (mem.exists(mem_req.addr[`PA_WIDTH-1:2]))
            mem_rsp.rdata = mem[mem_req.addr[`PA_WIDTH-1:2]];
    end

endmodule

// File: rtl/mmu_top.sv
// MMU front end: itlb and dtlb share one walker and one read-only memory port
`timescale 1ns/1ps

module mmu_top (
    input  logic                       CLK,
    input  logic                       nRST,
    input  priv_types_pkg::csr_state_t csr,
    input  logic                       flush,
    input  sv32_types_pkg::tlb_req_t   ireq,
    input  sv32_types_pkg::tlb_req_t   dreq,
    output sv32_types_pkg::tlb_rsp_t   irsp,
    output sv32_types_pkg::tlb_rsp_t   drsp,
    output sv32_types_pkg::mem_req_t   mem_req,
    input  sv32_types_pkg::mem_rsp_t   mem_rsp
);

    import sv32_types_pkg::*;

    logic      trans_on;  // from the walker only
    walk_req_t iwalk_req;
    walk_req_t dwalk_req;
    walk_rsp_t iwalk_rsp;
    walk_rsp_t dwalk_rsp;

    tlb itlb (
        .CLK      (CLK),
        .nRST     (nRST),
        .req      (ireq),
        .rsp      (irsp),
        .csr      (csr),
        .trans_on (trans_on),
        .flush    (flush),
        .walk_req (iwalk_req),
        .walk_rsp (iwalk_rsp)
    );

    tlb dtlb (
        .CLK      (CLK),
        .nRST     (nRST),
        .req      (dreq),
        .rsp      (drsp),
        .csr      (csr),
        .trans_on (trans_on),
        .flush    (flush),
        .walk_req (dwalk_req),
        .walk_rsp (dwalk_rsp)
    );

    page_walker walker (
        .CLK       (CLK),
        .nRST      (nRST),
        .csr       (csr),
        .trans_on  (trans_on),
        .dwalk_req (dwalk_req),
        .iwalk_req (iwalk_req),
        .dwalk_rsp (dwalk_rsp),
        .iwalk_rsp (iwalk_rsp),
        .mem_req   (mem_req),
        .mem_rsp   (mem_rsp)
    );

endmodule

// File: page_walker/page_walker.sv
// Sv32 walker, reads only; no A/D updates, no PMP or PMA checks, data misses walked first
`timescale 1ns/1ps
`include "mmu_defs.svh"

module page_walker (
    input  logic                       CLK,
    input  logic                       nRST,
    input  priv_types_pkg::csr_state_t csr,
    output logic                       trans_on,
    input  sv32_types_pkg::walk_req_t  dwalk_req,
    input  sv32_types_pkg::walk_req_t  iwalk_req,
    output sv32_types_pkg::walk_rsp_t  dwalk_rsp,
    output sv32_types_pkg::walk_rsp_t  iwalk_rsp,
    output sv32_types_pkg::mem_req_t   mem_req,
    input  sv32_types_pkg::mem_rsp_t   mem_rsp
);

    import priv_types_pkg::*;
    import sv32_types_pkg::*;

    localparam int LVL_W = (`SV32_LEVELS > 1) ? $clog2(`SV32_LEVELS) : 1;
    localparam int SEG_HI = `VPN_SEG_BITS - 1;

    typedef enum logic {
        IDLE,
        WALK
    } walk_state_t;

    walk_state_t      state;
    logic [LVL_W-1:0] level;
    paddr_t           page_addr;
    logic             serve_d;  // 1 while the data side is walked
    access_t          acc;

    logic      start;
    walk_req_t new_req;
    va_t       new_va;
    walk_req_t cur_req;
    va_t       cur_va;

    pte_t pte;
    pte_t leaf_out;
    logic rd_done;
    logic is_leaf;
    logic pte_bad;
    logic walk_fault;
    logic walk_fill;

    // M-mode never translates
    assign trans_on = csr.satp.mode && (csr.priv == S_MODE || csr.priv == U_MODE);

    // data before fetch
    assign start   = trans_on && (dwalk_req.miss || iwalk_req.miss);
    assign new_req = dwalk_req.miss ? dwalk_req : iwalk_req;
    assign new_va  = va_t'(new_req.vaddr);

    // serviced side keeps its request held for the whole walk
    assign cur_req = serve_d ? dwalk_req : iwalk_req;
    assign cur_va  = va_t'(cur_req.vaddr);

    assign pte     = pte_t'(mem_rsp.rdata);
    assign rd_done = (state == WALK) && !mem_rsp.busy;
    assign is_leaf = pte.perms.r || pte.perms.x;

    // PTE checks, only meaningful when rd_done
    always_comb begin
        pte_bad = 1'b0;
        if (!pte.perms.v || (pte.perms.w && !pte.perms.r)) begin
            pte_bad = 1'b1;
        end else if (!is_leaf) begin
            pte_bad = (level == '0);  // pointer with no level left
        end else begin
            pte_bad = leaf_denied(pte.perms, acc, csr) ||
                      (level != '0 && |pte.ppn[SEG_HI:0]);  // misaligned megapage
        end
    end

    assign walk_fault = rd_done && pte_bad;
    assign walk_fill  = rd_done && !pte_bad && is_leaf;

    // megapage becomes a 4 KiB entry for this vaddr
    always_comb begin
        leaf_out = pte;
        if (level != '0)
            leaf_out.ppn = {pte.ppn[`PPN_WIDTH-1:`VPN_SEG_BITS], cur_va.vpn[0]};
    end

    always_ff @(posedge CLK) begin
        if (!nRST) begin
            state   <= IDLE;
            level   <= '0;
            serve_d <= 1'b0;
            acc     <= NONE;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state   <= WALK;
                        level   <= LVL_W'(`SV32_LEVELS - 1);
                        serve_d <= dwalk_req.miss;
                        acc     <= new_req.access;
                    end
                end
                WALK: begin
                    if (walk_fault || walk_fill) begin
                        state <= IDLE;
                        acc   <= NONE;
                    end else if (rd_done) begin
                        level <= level - 1'b1;  // pointer, go down
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // held while busy since rd_done stays low
    always_ff @(posedge CLK) begin
        if (state == IDLE)
            page_addr <= {csr.satp.ppn, new_va.vpn[`SV32_LEVELS-1], 2'b00};
        else if (rd_done)
            page_addr <= {pte.ppn, cur_va.vpn[0], 2'b00};
    end

    always_comb begin
        dwalk_rsp.fill  = walk_fill && serve_d;
        dwalk_rsp.fault = walk_fault && serve_d;
        dwalk_rsp.leaf  = leaf_out;
        iwalk_rsp.fill  = walk_fill && !serve_d;
        iwalk_rsp.fault = walk_fault && !serve_d;
        iwalk_rsp.leaf  = leaf_out;
        mem_req.ren     = (state == WALK);
        mem_req.addr    = page_addr;
    end

endmodule

// File: tlb/tlb.sv
// fully associative, round-robin refill; no asid so flush drops every entry, faults give paddr 0
`timescale 1ns/1ps
`include "mmu_defs.svh"

module tlb (
    input  logic                       CLK,
    input  logic                       nRST,
    input  sv32_types_pkg::tlb_req_t   req,
    output sv32_types_pkg::tlb_rsp_t   rsp,
    input  priv_types_pkg::csr_state_t csr,
    input  logic                       trans_on,
    input  logic                       flush,
    output sv32_types_pkg::walk_req_t  walk_req,
    input  sv32_types_pkg::walk_rsp_t  walk_rsp
);

    import priv_types_pkg::*;
    import sv32_types_pkg::*;

    localparam int IDX_W = (`TLB_ENTRIES > 1) ? $clog2(`TLB_ENTRIES) : 1;
    localparam int TAG_W = 2 * `VPN_SEG_BITS;

    // entry storage
    logic [`TLB_ENTRIES-1:0] valid;
    logic [TAG_W-1:0]        tags [`TLB_ENTRIES];
    pte_t                    ptes [`TLB_ENTRIES];
    logic [IDX_W-1:0]        repl_ptr;

    va_t              va;
    logic [TAG_W-1:0] req_tag;
    logic             lookup;
    logic             hit;
    logic             denied;
    pte_t             hit_pte;

    logic   miss_q;
    logic   done_q;
    logic   fault_q;
    paddr_t paddr_q;

    assign va      = va_t'(req.vaddr);
    assign req_tag = va.vpn;
    // no new lookup while a walk is pending or done is out
    assign lookup  = req.valid && !done_q && !miss_q;

    always_comb begin
        hit     = 1'b0;
        hit_pte = '0;
        for (int i = 0; i < `TLB_ENTRIES; i++) begin
            if (!hit && valid[i] && tags[i] == req_tag) begin
                hit     = 1'b1;
                hit_pte = ptes[i];
            end
        end
    end

    assign denied = leaf_denied(hit_pte.perms, req.access, csr);  // rechecked on every hit

    always_ff @(posedge CLK) begin
        if (!nRST) begin
            miss_q  <= 1'b0;
            done_q  <= 1'b0;
            fault_q <= 1'b0;
        end else begin
            done_q  <= 1'b0;
            fault_q <= 1'b0;
            if (miss_q) begin
                if (walk_rsp.fill) begin
                    miss_q <= 1'b0;  // entry written, next cycle hits
                end else if (walk_rsp.fault) begin
                    miss_q  <= 1'b0;
                    done_q  <= 1'b1;
                    fault_q <= 1'b1;
                end
            end else if (lookup) begin
                if (!trans_on || hit) begin
                    done_q  <= 1'b1;
                    fault_q <= trans_on && denied;
                end else begin
                    miss_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (miss_q && walk_rsp.fault) begin
            paddr_q <= '0;
        end else if (lookup) begin
            if (!trans_on)
                paddr_q <= paddr_t'(req.vaddr);  // bare, zero extended
            else if (hit && !denied)
                paddr_q <= {hit_pte.ppn, va.offset};
            else
                paddr_q <= '0;
        end
    end

    // valid bits and replacement pointer
    always_ff @(posedge CLK) begin
        if (!nRST) begin
            valid    <= '0;
            repl_ptr <= '0;
        end else if (flush) begin
            valid <= '0;
        end else if (miss_q && walk_rsp.fill) begin
            valid[repl_ptr] <= 1'b1;
            repl_ptr <= (repl_ptr == IDX_W'(`TLB_ENTRIES - 1)) ? '0 : repl_ptr + 1'b1;
        end
    end

    always_ff @(posedge CLK) begin
        if (miss_q && walk_rsp.fill) begin
            tags[repl_ptr] <= req_tag;
            ptes[repl_ptr] <= walk_rsp.leaf;
        end
    end

    always_comb begin
        walk_req.miss   = miss_q;
        walk_req.access = req.access;
        walk_req.vaddr  = req.vaddr;  // held by the requester
        rsp.done        = done_q;
        rsp.fault       = fault_q;
        rsp.paddr       = paddr_q;
    end

endmodule

// File: common/sv32_types_pkg.sv
// Sv32 paging types; no accessed or dirty bit updates, leaf permission rule lives here only
`include "mmu_defs.svh"

package sv32_types_pkg;

    import priv_types_pkg::*;

    typedef struct packed {
        logic [1:0] rsw;
        logic       d;
        logic       a;
        logic       g;
        logic       u;
        logic       x;
        logic       w;
        logic       r;
        logic       v;
    } pte_perms_t;

    typedef struct packed {
        ppn_t       ppn;
        pte_perms_t perms;
    } pte_t;

    typedef struct packed {
        logic [1:0][`VPN_SEG_BITS-1:0] vpn;  // vpn[1] is the upper segment
        logic [`PG_BITS-1:0]           offset;
    } va_t;

    typedef enum logic [1:0] {
        NONE,
        LOAD,
        STORE,
        FETCH
    } access_t;

    // core side, valid held until done
    typedef struct packed {
        logic    valid;
        access_t access;
        word_t   vaddr;
    } tlb_req_t;

    typedef struct packed {
        logic   done;   // one cycle pulse
        logic   fault;
        paddr_t paddr;
    } tlb_rsp_t;

    // TLB to walker, miss held until answered
    typedef struct packed {
        logic    miss;
        access_t access;
        word_t   vaddr;
    } walk_req_t;

    typedef struct packed {
        logic fill;
        logic fault;
        pte_t leaf;   // always a 4 KiB entry
    } walk_rsp_t;

    typedef struct packed {
        logic   ren;
        paddr_t addr;
    } mem_req_t;

    typedef struct packed {
        logic  busy;
        word_t rdata;  // valid when busy is low
    } mem_rsp_t;

    // true when a valid leaf refuses this access
    function automatic logic leaf_denied(input pte_perms_t perms, input access_t access,
                                         input csr_state_t csr);
        logic u_bad;
        u_bad = (perms.u && csr.priv == S_MODE && !csr.sum) ||
                (!perms.u && csr.priv == U_MODE);
        return (access == FETCH && !perms.x) || (access == STORE && !perms.w) || u_bad;
    endfunction

endpackage

// File: common/priv_types_pkg.sv
// privilege-side types; satp carries an asid field but no block here compares it
`include "mmu_defs.svh"

package priv_types_pkg;

    typedef logic [`WORD_WIDTH-1:0] word_t;  // vaddr or pte
    typedef logic [`PA_WIDTH-1:0] paddr_t;
    typedef logic [`PPN_WIDTH-1:0] ppn_t;

    // encodings as in mstatus.mpp
    typedef enum logic [1:0] {
        U_MODE = 2'b00,
        S_MODE = 2'b01,
        M_MODE = 2'b11
    } priv_level_t;

    typedef struct packed {
        logic       mode;  // 1 selects sv32
        logic [8:0] asid;
        ppn_t       ppn;   // root table page
    } satp_t;

    // csr view shared by the walker and both TLBs
    typedef struct packed {
        satp_t       satp;
        priv_level_t priv;
        logic        sum;  // mstatus.sum
    } csr_state_t;

endpackage

// File: common/mmu_defs.svh
// Sv32 only: 34-bit physical addresses and 4 KiB base pages, no wider paging modes
`ifndef MMU_DEFS_SVH
`define MMU_DEFS_SVH

// entries in each fully associative TLB
`define TLB_ENTRIES 4

// upper bound on cycles per memory read, busy included
`define MEM_MAX_LAT 4

// address widths
`define WORD_WIDTH 32
`define PA_WIDTH 34
`define PPN_WIDTH 22
`define PG_BITS 12
`define VPN_SEG_BITS 10

// two-level table walk
`define SV32_LEVELS 2

`endif
